// File: hdl/spi_flash_pkg.sv
`default_nettype none

package spi_flash_pkg;

    localparam int NUM_CH = 2;                      // works for 1 to 4.

    localparam int CODE_W = 8;
    localparam int ADDR_W = 24;
    localparam int DATA_W = 32;
    localparam int SR_W   = CODE_W + ADDR_W;        // code and address as one shift word.

    // paddr[5:4] selects the channel and paddr[3:2] the register.
    localparam int APB_AW  = 8;
    localparam int CH_W    = 2;
    localparam int CH_LSB  = 4;
    localparam int REG_LSB = 2;

    localparam logic [1:0] REG_CMD  = 2'd0;
    localparam logic [1:0] REG_ADDR = 2'd1;
    localparam logic [1:0] REG_DATA = 2'd2;
    localparam logic [1:0] REG_STAT = 2'd3;

    localparam int CMD_ADDR_BIT = CODE_W;           // address phase follows the code.
    localparam int CMD_INC_BIT  = CODE_W + 1;       // post-increment after launch.

    localparam int STAT_VALID_BIT = 0;
    localparam int STAT_BUSY_BIT  = 1;

    // one lead-in tick with cs low and sck idle, then the bits.
    localparam int TICKS_CODE = 1 + CODE_W + DATA_W;
    localparam int TICKS_ADDR = 1 + CODE_W + ADDR_W + DATA_W;
    localparam int CNT_W      = $clog2(TICKS_ADDR + 1);

    localparam int STALL_MAX = 2 * TICKS_ADDR + 2;  // longest pready stall in ck cycles.

    typedef struct packed {
        logic [CODE_W-1:0] code;
        logic [ADDR_W-1:0] addr;
        logic              has_addr;
    } spi_cmd_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
    } spi_resp_t;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [APB_AW-1:0] paddr;
        logic [DATA_W-1:0] pwdata;
    } apb_req_t;

endpackage

`default_nettype wire

// File: hdl/spi_cmd_regs.sv
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_regs import spi_flash_pkg::*; (
    input  logic                   ck,
    input  logic                   rst_n,
    input  apb_req_t               apb_req,
    output logic [DATA_W-1:0]      prdata,
    output logic                   pready,
    output logic [NUM_CH-1:0]      start,
    output spi_cmd_t [NUM_CH-1:0]  cmd,
    input  logic [NUM_CH-1:0]      busy,
    output logic [NUM_CH-1:0]      rd_clr,
    input  spi_resp_t [NUM_CH-1:0] data,
    input  logic [NUM_CH-1:0]      valid
);

    logic [CH_W-1:0]                ch_sel;
    logic [1:0]                     reg_sel;
    logic                           hit;
    logic                           access;
    logic [NUM_CH-1:0]              ch_hit;
    logic [NUM_CH-1:0]              cmd_wr;
    logic [NUM_CH-1:0]              addr_wr;
    logic [NUM_CH-1:0]              stall;
    logic [NUM_CH-1:0]              start_q;
    logic [NUM_CH-1:0]              inc_q;
    spi_cmd_t [NUM_CH-1:0]          cmd_q;
    logic [NUM_CH-1:0][ADDR_W-1:0]  addr_q;

    assign ch_sel  = apb_req.paddr[CH_LSB +: CH_W];
    assign reg_sel = apb_req.paddr[REG_LSB +: 2];
    assign hit     = apb_req.psel && (apb_req.paddr[APB_AW-1:CH_LSB+CH_W] == '0);
    assign access  = hit && apb_req.penable;

    always_comb begin
        for (int c = 0; c < NUM_CH; c++) begin
            ch_hit[c]  = access && (ch_sel == CH_W'(c));
            cmd_wr[c]  = ch_hit[c] && apb_req.pwrite && (reg_sel == REG_CMD);
            addr_wr[c] = ch_hit[c] && apb_req.pwrite && (reg_sel == REG_ADDR);
            rd_clr[c]  = ch_hit[c] && !apb_req.pwrite && (reg_sel == REG_DATA);
            stall[c]   = cmd_wr[c] && (busy[c] || start_q[c]);  // hold until engine idle.
        end
    end

    assign pready = ~|stall;

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            start_q <= '0;
        end else begin
            for (int c = 0; c < NUM_CH; c++) begin
                start_q[c] <= cmd_wr[c] && pready;
            end
        end
    end

    // the engine gets the old address while the register moves on.
    always_ff @(posedge ck) begin
        for (int c = 0; c < NUM_CH; c++) begin
            if (cmd_wr[c] && pready) begin
                cmd_q[c].code     <= apb_req.pwdata[CODE_W-1:0];
                cmd_q[c].has_addr <= apb_req.pwdata[CMD_ADDR_BIT];
                cmd_q[c].addr     <= addr_q[c];
                inc_q[c]          <= apb_req.pwdata[CMD_INC_BIT];
                if (apb_req.pwdata[CMD_INC_BIT]) begin
                    addr_q[c] <= addr_q[c] + ADDR_W'(1);
                end
            end else if (addr_wr[c]) begin
                addr_q[c] <= apb_req.pwdata[ADDR_W-1:0];
            end
        end
    end

    assign start = start_q;
    assign cmd   = cmd_q;

    always_comb begin
        prdata = '0;
        for (int c = 0; c < NUM_CH; c++) begin
            if (hit && !apb_req.pwrite && (ch_sel == CH_W'(c))) begin
                case (reg_sel)
                    REG_CMD: begin
                        prdata[CODE_W-1:0]  = cmd_q[c].code;
                        prdata[CMD_ADDR_BIT] = cmd_q[c].has_addr;
                        prdata[CMD_INC_BIT]  = inc_q[c];
                    end
                    REG_ADDR: begin
                        prdata[ADDR_W-1:0] = addr_q[c];
                    end
                    REG_DATA: begin
                        prdata = data[c].data;
                    end
                    default: begin
                        prdata[STAT_VALID_BIT] = valid[c];
                        prdata[STAT_BUSY_BIT]  = busy[c];
                    end
                endcase
            end
        end
    end

    // a stalled command write is taken once the longest transfer has drained.
    a_stall_bounded: assert property (@(posedge ck) disable iff (!rst_n)
        $fell(pready) |-> ##[1:STALL_MAX] pready);

endmodule

`default_nettype wire

// File: hdl/spi_engine.sv
`timescale 1ns/1ps
`default_nettype none

module spi_engine import spi_flash_pkg::*; (
    input  logic      ck,
    input  logic      rst_n,
    input  logic      start,
    input  spi_cmd_t  cmd,
    output logic      busy,
    output logic      done,
    output spi_resp_t resp,
    output logic      cs,
    output logic      sck,
    output logic      mosi,
    input  logic      miso
);

    logic             busy_q;
    logic             done_q;
    logic             phase_q;
    logic             lead_q;
    logic [CNT_W-1:0] cnt_q;
    logic [SR_W-1:0]  sr_q;
    logic [DATA_W-1:0] rx_q;
    spi_resp_t        resp_q;
    logic             launch;
    logic             tick_end;
    logic             last;

    assign launch   = start && !busy_q;
    assign tick_end = busy_q && phase_q;    // sck falls on this edge.
    assign last     = tick_end && (cnt_q == CNT_W'(1));

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            phase_q <= 1'b0;
            lead_q  <= 1'b0;
            cnt_q   <= '0;
        end else begin
            done_q <= 1'b0;
            if (launch) begin
                busy_q  <= 1'b1;
                phase_q <= 1'b0;
                lead_q  <= 1'b1;
                cnt_q   <= cmd.has_addr ? CNT_W'(TICKS_ADDR) : CNT_W'(TICKS_CODE);
            end else if (busy_q) begin
                phase_q <= !phase_q;
                if (tick_end) begin
                    lead_q <= 1'b0;
                    cnt_q  <= cnt_q - CNT_W'(1);
                end
                if (last) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge ck) begin
        if (launch) begin
            sr_q <= {cmd.code, cmd.has_addr ? cmd.addr : {ADDR_W{1'b0}}};
        end else if (tick_end && !lead_q) begin
            sr_q <= {sr_q[SR_W-2:0], 1'b0};
            rx_q <= {rx_q[DATA_W-2:0], miso};
        end
        if (last) begin
            resp_q.data <= {rx_q[DATA_W-2:0], miso};  // include the final sample.
        end
    end

    assign busy = busy_q;
    assign done = done_q;
    assign resp = resp_q;

    assign cs   = !busy_q;
    assign sck  = busy_q && phase_q && !lead_q;
    assign mosi = busy_q ? sr_q[SR_W-1] : 1'b1;

    a_no_start_busy: assert property (@(posedge ck) disable iff (!rst_n)
        start |-> !busy_q);

endmodule

`default_nettype wire

// File: hdl/spi_result_bank.sv
`timescale 1ns/1ps
`default_nettype none

module spi_result_bank import spi_flash_pkg::*; (
    input  logic                   ck,
    input  logic                   rst_n,
    input  logic [NUM_CH-1:0]      done,
    input  spi_resp_t [NUM_CH-1:0] resp,
    input  logic [NUM_CH-1:0]      rd_clr,
    output spi_resp_t [NUM_CH-1:0] data,
    output logic [NUM_CH-1:0]      valid
);

    spi_resp_t [NUM_CH-1:0] data_q;
    logic [NUM_CH-1:0]      valid_q;

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            for (int c = 0; c < NUM_CH; c++) begin
                if (done[c]) begin
                    valid_q[c] <= 1'b1;     // a fresh word beats the clear.
                end else if (rd_clr[c]) begin
                    valid_q[c] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge ck) begin
        for (int c = 0; c < NUM_CH; c++) begin
            if (done[c]) begin
                data_q[c] <= resp[c];
            end
        end
    end

    assign data  = data_q;
    assign valid = valid_q;

endmodule

`default_nettype wire

// File: hdl/spi_flash_top.sv
`timescale 1ns/1ps
`default_nettype none

module spi_flash_top import spi_flash_pkg::*; (
    input  logic              ck,
    input  logic              rst_n,
    input  apb_req_t          apb_req,
    output logic [DATA_W-1:0] prdata,
    output logic              pready,
    output logic [NUM_CH-1:0] cs,
    output logic [NUM_CH-1:0] sck,
    output logic [NUM_CH-1:0] mosi,
    input  logic [NUM_CH-1:0] miso
);

    logic [NUM_CH-1:0]      start;
    logic [NUM_CH-1:0]      busy;
    logic [NUM_CH-1:0]      done;
    logic [NUM_CH-1:0]      rd_clr;
    logic [NUM_CH-1:0]      valid;
    spi_cmd_t [NUM_CH-1:0]  cmd;
    spi_resp_t [NUM_CH-1:0] resp;
    spi_resp_t [NUM_CH-1:0] data;

    spi_cmd_regs u_regs (
        .ck      (ck),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .prdata  (prdata),
        .pready  (pready),
        .start   (start),
        .cmd     (cmd),
        .busy    (busy),
        .rd_clr  (rd_clr),
        .data    (data),
        .valid   (valid)
    );

    for (genvar i = 0; i < NUM_CH; i++) begin : eng
        spi_engine u_engine (
            .ck    (ck),
            .rst_n (rst_n),
            .start (start[i]),
            .cmd   (cmd[i]),
            .busy  (busy[i]),
            .done  (done[i]),
            .resp  (resp[i]),
            .cs    (cs[i]),
            .sck   (sck[i]),
            .mosi  (mosi[i]),
            .miso  (miso[i])
        );
    end

    spi_result_bank u_bank (
        .ck     (ck),
        .rst_n  (rst_n),
        .done   (done),
        .resp   (resp),
        .rd_clr (rd_clr),
        .data   (data),
        .valid  (valid)
    );

endmodule

`default_nettype wire

// File: tb/spi_flash_model.sv
`timescale 1ns/1ps
`default_nettype none

module spi_flash_model import spi_flash_pkg::*; (
    input  logic cs,
    input  logic sck,
    input  logic mosi,
    output logic miso
);

    // takes the command bits on rising sck, then replies msb first on falling sck.
    task automatic serve_transfer;
        logic [SR_W-1:0]   hdr;
        logic [DATA_W-1:0] word;
        int                need;
        hdr  = '0;
        need = CODE_W;
        for (int n = 0; n < need; n++) begin
            @(posedge sck or posedge cs);
            if (cs) begin
                return;
            end
            hdr = {hdr[SR_W-2:0], mosi};
            if (n == CODE_W - 1 && hdr[CODE_W-1]) begin
                need = CODE_W + ADDR_W;                 // bit 7 set means an address follows.
            end
        end
        if (need == CODE_W) begin
            word = {4{hdr[CODE_W-1:0]}};
        end else begin
            word = {~hdr[SR_W-1 -: CODE_W], hdr[ADDR_W-1:0]};
        end
        for (int b = DATA_W - 1; b >= 0; b--) begin
            @(negedge sck or posedge cs);
            if (cs) begin
                return;
            end
            miso = word[b];
        end
    endtask

    initial begin
        miso = 1'b0;
        forever begin
            @(negedge cs);
            serve_transfer();
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_spi_flash.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_flash import spi_flash_pkg::*; ();

    localparam int STALL_LIMIT = 2 * (1 + CODE_W + ADDR_W + DATA_W) + 8;
    localparam int POLL_LIMIT  = STALL_LIMIT;

    logic              ck;
    logic              rst_n;
    apb_req_t          apb_req;
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic [NUM_CH-1:0] cs;
    logic [NUM_CH-1:0] sck;
    logic [NUM_CH-1:0] mosi;
    wire  [NUM_CH-1:0] miso;

    logic [31:0]       lfsr;
    logic [NUM_CH-1:0] pending;                         // a launched word not yet read back.
    spi_resp_t         pend_resp [NUM_CH];
    logic [ADDR_W-1:0] exp_addr [NUM_CH];
    logic [NUM_CH-1:0] addr_known;
    int                stalls_seen;

    spi_flash_top dut0 (
        .ck      (ck),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .prdata  (prdata),
        .pready  (pready),
        .cs      (cs),
        .sck     (sck),
        .mosi    (mosi),
        .miso    (miso)
    );

    for (genvar i = 0; i < NUM_CH; i++) begin : flash
        spi_flash_model u_model (
            .cs   (cs[i]),
            .sck  (sck[i]),
            .mosi (mosi[i]),
            .miso (miso[i])
        );
    end

    initial begin
        ck = 1'b0;
        forever #2 ck = ~ck;
    end

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v    = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    function automatic logic [APB_AW-1:0] reg_addr(input int ch, input logic [1:0] rg);
        logic [APB_AW-1:0] a;
        a = '0;
        a[CH_LSB +: CH_W] = CH_W'(ch);
        a[REG_LSB +: 2]   = rg;
        return a;
    endfunction

    function automatic logic [DATA_W-1:0] cmd_word(input logic [CODE_W-1:0] code,
                                                   input logic has_addr, input logic inc);
        logic [DATA_W-1:0] w;
        w = '0;
        w[CODE_W-1:0]   = code;
        w[CMD_ADDR_BIT] = has_addr;
        w[CMD_INC_BIT]  = inc;
        return w;
    endfunction

    task automatic check_pin(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_stop($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_resp(input int ch, input spi_resp_t got, input spi_resp_t exp);
        if (got !== exp) begin
            fail_stop($sformatf("ERROR ch%0d prdata got 0x%08h expected 0x%08h",
                                ch, got.data, exp.data));
        end
    endtask

    task automatic check_stat(input int ch, input logic valid, input logic busy,
                              input logic exp_valid, input logic exp_busy);
        check_pin($sformatf("ch%0d valid", ch), valid, exp_valid);
        check_pin($sformatf("ch%0d busy", ch), busy, exp_busy);
    endtask

    task automatic check_addr(input int ch, input logic [ADDR_W-1:0] got,
                              input logic [ADDR_W-1:0] exp);
        if (got !== exp) begin
            fail_stop($sformatf("ERROR ch%0d addr got 0x%06h expected 0x%06h", ch, got, exp));
        end
    endtask

    task automatic apb_write(input int ch, input logic [1:0] rg,
                             input logic [DATA_W-1:0] wdata, output int stalled);
        apb_req_t req;
        req        = '0;
        req.psel   = 1'b1;
        req.pwrite = 1'b1;
        req.paddr  = reg_addr(ch, rg);
        req.pwdata = wdata;
        stalled    = 0;
        @(posedge ck);
        apb_req <= req;
        req.penable = 1'b1;
        @(posedge ck);
        apb_req <= req;
        @(negedge ck);
        while (!pready) begin
            check_pin($sformatf("cs[%0d]", ch), cs[ch], 1'b0);  // held only behind a transfer.
            stalled++;
            if (stalled > STALL_LIMIT) begin
                fail_stop($sformatf("write to channel %0d was held off too long", ch));
            end
            @(negedge ck);
        end
        if (rg == REG_CMD) begin
            check_pin($sformatf("cs[%0d]", ch), cs[ch], 1'b1);
        end
        @(posedge ck);
        apb_req <= '0;
    endtask

    task automatic apb_read(input int ch, input logic [1:0] rg, output logic [DATA_W-1:0] word);
        apb_req_t req;
        req       = '0;
        req.psel  = 1'b1;
        req.paddr = reg_addr(ch, rg);
        @(posedge ck);
        apb_req <= req;
        req.penable = 1'b1;
        @(posedge ck);
        apb_req <= req;
        @(negedge ck);
        check_pin("pready", pready, 1'b1);                   // reads take no wait state.
        word = prdata;
        @(posedge ck);
        apb_req <= '0;
    endtask

    // waits for valid, checks it is sticky, reads the word and sees valid clear.
    task automatic collect(input int ch, input spi_resp_t exp, input logic exp_busy);
        logic [DATA_W-1:0] word;
        spi_resp_t         got;
        int                polls;
        polls = 0;
        apb_read(ch, REG_STAT, word);
        while (!word[STAT_VALID_BIT]) begin
            polls++;
            if (polls > POLL_LIMIT) begin
                fail_stop($sformatf("channel %0d never reported a valid result", ch));
            end
            apb_read(ch, REG_STAT, word);
        end
        check_stat(ch, word[STAT_VALID_BIT], word[STAT_BUSY_BIT], 1'b1, exp_busy);
        repeat (2) @(posedge ck);
        apb_read(ch, REG_STAT, word);
        check_stat(ch, word[STAT_VALID_BIT], word[STAT_BUSY_BIT], 1'b1, exp_busy);
        apb_read(ch, REG_DATA, word);
        got.data = word;
        check_resp(ch, got, exp);
        apb_read(ch, REG_STAT, word);
        check_stat(ch, word[STAT_VALID_BIT], word[STAT_BUSY_BIT], 1'b0, exp_busy);
        pending[ch] = 1'b0;
    endtask

    task automatic run_line(input int ch, input logic [CODE_W-1:0] code,
                            input logic [ADDR_W-1:0] addr, input logic has_addr,
                            input logic inc, input logic [DATA_W-1:0] exp_word);
        int                stalled;
        logic [DATA_W-1:0] word;
        spi_resp_t         exp_resp;
        exp_resp.data = exp_word;
        repeat (take_bits(3)) @(posedge ck);
        if (!addr_known[ch] || exp_addr[ch] !== addr) begin
            apb_write(ch, REG_ADDR, DATA_W'(addr), stalled);
            exp_addr[ch]   = addr;
            addr_known[ch] = 1'b1;
        end
        apb_write(ch, REG_CMD, cmd_word(code, has_addr, inc), stalled);
        if (stalled > 0) begin
            stalls_seen++;
        end
        if (inc) begin
            exp_addr[ch] = exp_addr[ch] + ADDR_W'(1);
            apb_read(ch, REG_ADDR, word);
            check_addr(ch, word[ADDR_W-1:0], exp_addr[ch]);
        end
        if (pending[ch]) begin
            collect(ch, pend_resp[ch], 1'b1);          // the new command is running.
        end
        pending[ch]   = 1'b1;
        pend_resp[ch] = exp_resp;
    endtask

    task automatic run_golden;
        int                fd;
        int                n;
        int                lines;
        string             line;
        int                ch;
        logic [CODE_W-1:0] code;
        logic [ADDR_W-1:0] addr;
        logic              has_addr;
        logic              inc;
        logic [DATA_W-1:0] exp_word;
        lines = 0;
        fd = $fopen("tb/spi_flash_golden.txt", "r");
        if (fd == 0) begin
            fail_stop("cannot open tb/spi_flash_golden.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h", ch, code, addr, has_addr, inc, exp_word);
            if (n != 6 || ch >= NUM_CH) begin
                fail_stop($sformatf("malformed golden line: %s", line));
            end
            run_line(ch, code, addr, has_addr, inc, exp_word);
            lines++;
        end
        $fclose(fd);
        if (lines == 0) begin
            fail_stop("golden file holds no transactions");
        end
    endtask

    task automatic check_reset_state;
        logic [DATA_W-1:0] word;
        @(negedge ck);
        for (int c = 0; c < NUM_CH; c++) begin
            check_pin($sformatf("cs[%0d]", c), cs[c], 1'b1);
        end
        for (int c = 0; c < NUM_CH; c++) begin
            apb_read(c, REG_STAT, word);
            check_stat(c, word[STAT_VALID_BIT], word[STAT_BUSY_BIT], 1'b0, 1'b0);
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        apb_req     = '0;
        lfsr        = 32'h5003_ca8b;
        pending     = '0;
        addr_known  = '0;
        stalls_seen = 0;
        repeat (10) @(posedge ck);
        rst_n <= 1'b1;
        check_reset_state();
        run_golden();
        for (int c = 0; c < NUM_CH; c++) begin
            if (pending[c]) begin
                collect(c, pend_resp[c], 1'b0);
            end
        end
        if (stalls_seen == 0) begin
            fail_stop("no command write was ever held off by a busy channel");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: spi_flash.f
hdl/spi_flash_pkg.sv
hdl/spi_cmd_regs.sv
hdl/spi_engine.sv
hdl/spi_result_bank.sv
hdl/spi_flash_top.sv
tb/spi_flash_model.sv
tb/tb_spi_flash.sv

// File: tb/spi_flash_golden.txt
# stimulus and expected replies for tb_spi_flash, all fields in hex.
# columns: channel code address has_addr increment expected_word
0 05 000000 0 0 05050505
1 9f 012345 1 0 60012345
0 03 000000 0 0 03030303
1 0b 000000 0 0 0b0b0b0b
0 eb 100000 1 1 14100000
0 eb 100001 1 1 14100001
0 eb 100002 1 1 14100002
1 9f fffffe 1 1 60fffffe
1 9f ffffff 1 1 60ffffff
1 03 000000 0 1 03030303
0 3b 000000 0 0 3b3b3b3b
0 bb abcdef 1 0 44abcdef
1 6b 000001 0 0 6b6b6b6b
1 ab 5a5a5a 1 0 545a5a5a
0 ff c3c3c3 1 0 00c3c3c3
1 7f 000000 0 1 7f7f7f7f
0 81 800000 1 1 7e800000
0 01 800001 0 0 01010101
1 c5 0f0f0f 1 0 3a0f0f0f
1 55 000000 0 0 55555555
